//--- Makefile
TOP       ?= tb_fog_loop
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FLIST     ?= vlog.f

VFLAGS = --binary --timing --assert --timescale 1ns/100ps \
	-f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "overridable: TOP LOG VERILATOR OBJ_DIR FLIST"

test:
	$(VERILATOR) $(VFLAGS)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) && echo "result: pass" || \
		(echo "result: fail"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/fog_loop_sva.sv
module fog_loop_sva (
	input  logic                       CLOCK_DAC_1,
	input  logic                       i_rst,
	input  fog_ctrl_pkg::loop_cfg_t    i_cfg,
	input  fog_ctrl_pkg::mod_strobe_t  i_strobe
);

	timeunit 1ns;
	timeprecision 100ps;

	import fog_dsp_pkg::*;
	import fog_ctrl_pkg::*;

	// failed assertions, read by the testbench at the end
	int fail_cnt = 0;
	// position of the previous cycle inside its half, 1-based
	logic [DATA_W-1:0] len_q;
	logic [DATA_W-1:0] len_now;

	assign len_now = i_strobe.step_trig ? DATA_W'(1) : len_q + DATA_W'(1);

	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			len_q <= '0;
		end else begin
			len_q <= len_now;
		end
	end

	// switch pulse only on a status edge
	trig_on_toggle: assert property (@(posedge CLOCK_DAC_1) disable iff (i_rst)
		i_strobe.step_trig == (i_strobe.status != $past(i_strobe.status)))
	else begin
		$error("step_trig and status change disagree");
		fail_cnt++;
	end

	// every half is exactly freq_cnt clocks long
	half_length: assert property (@(posedge CLOCK_DAC_1) disable iff (i_rst)
		i_strobe.step_trig == (len_q == DATA_W'(i_cfg.freq_cnt)))
	else begin
		$error("modulation half does not last freq_cnt cycles");
		fail_cnt++;
	end

	// loop always restarts in the low half
	low_after_reset: assert property (@(posedge CLOCK_DAC_1)
		$fell(i_rst) |-> (i_strobe.status == STATUS_LOW))
	else begin
		$error("status not low after reset");
		fail_cnt++;
	end

endmodule

bind fog_mod_gen fog_loop_sva u_mod_sva (
	.CLOCK_DAC_1 (CLOCK_DAC_1),
	.i_rst       (i_rst),
	.i_cfg       (i_cfg),
	.i_strobe    (o_strobe)
);

//--- bench/tb_fog_loop.sv
module tb_fog_loop;

	timeunit 1ns;
	timeprecision 100ps;

	import fog_dsp_pkg::*;
	import fog_ctrl_pkg::*;

	localparam int NUM_ROWS = 6;
	localparam int RST_CYCLES = 16;

	// one stimulus row with levels in raw adc counts
	typedef struct packed {
		loop_cfg_t cfg;
		int        lev_h;
		int        lev_l;
		// readback expected after the third period
		int        exp_err;
		int        exp_step3;
		int        periods;
	} row_t;

	logic             clock_dac_1;
	logic             rst;
	loop_cfg_t        cfg;
	logic [ADC_W-1:0] adc;
	dac_word_t        dac;
	loop_word_t       err;
	loop_word_t       step;
	logic             mod_status;

	row_t        rows [NUM_ROWS];
	logic [31:0] rng;
	int          cycle_cnt;
	int          cycle_limit;

	fog_loop_top u_dut (
		.CLOCK_DAC_1  (clock_dac_1),
		.i_rst        (rst),
		.i_cfg        (cfg),
		.i_adc        (adc),
		.o_dac        (dac),
		.o_err        (err),
		.o_step       (step),
		.o_mod_status (mod_status)
	);

	// 100 MHz dac clock
	initial begin
		clock_dac_1 = 1'b0;
		forever #5 clock_dac_1 = ~clock_dac_1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// steady-state fir output for a constant input
	function automatic int fir_settled(input int x);
		longint sum;
		sum = 0;
		for (int i = 0; i < FIR_TAPS; i++) begin
			sum += longint'(x) * longint'(fir_coef[i]);
		end
		return int'(sum >>> FIR_SHIFT);
	endfunction

	function automatic row_t make_row(input int freq, input int amp_h, input int amp_l,
			input int wait_c, input int offset, input int cstep, input int avg_sel,
			input int gs, input int gr, input int pol, input int fb, input int lev_h,
			input int lev_l, input int exp_err, input int exp_step3, input int periods);
		row_t r;
		r.cfg.freq_cnt = freq;
		r.cfg.amp_h = amp_h;
		r.cfg.amp_l = amp_l;
		r.cfg.wait_cnt = wait_c;
		r.cfg.err_offset = offset;
		r.cfg.const_step = cstep;
		r.cfg.avg_sel = avg_sel[2:0];
		r.cfg.gain_step = gs[4:0];
		r.cfg.gain_ramp = gr[4:0];
		r.cfg.polarity = pol[0];
		r.cfg.fb_on = fb[0];
		r.lev_h = lev_h;
		r.lev_l = lev_l;
		r.exp_err = exp_err;
		r.exp_step3 = exp_step3;
		r.periods = periods;
		return r;
	endfunction

	task automatic check_value(input string what, input longint got, input longint exp);
		if (got != exp) begin
			$display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clock_dac_1);
		#1;
	endtask

	task automatic run_row(input row_t row);
		int fh;
		int fl;
		int e_ref;
		int step_ref;
		int periods;
		int half_cycles;
		int mid;
		int tmp;
		logic status;
		logic prev_status;
		logic done;
		logic have_prev [2];
		logic [DAC_W-1:0] exp_dac;
		logic [DAC_W-1:0] got_diff;
		logic [DAC_W-1:0] prev_dac [2];

		// reference error from the settled fir levels
		fh = fir_settled(row.lev_h);
		fl = fir_settled(row.lev_l);
		e_ref = (row.cfg.polarity ? fl - fh : fh - fl) - int'(row.cfg.err_offset);

		// noise during reset is flushed out of the fir before the first window
		rst = 1'b1;
		cfg = row.cfg;
		repeat (RST_CYCLES) begin
			rng = xorshift32(rng);
			adc = rng[ADC_W-1:0];
			next_cycle();
		end
		rst = 1'b0;
		adc = row.lev_l[ADC_W-1:0];
		check_value("o_err after reset", longint'(err), 0);
		check_value("o_step after reset", longint'(step), 0);
		check_value("o_dac after reset", longint'(dac), 0);
		check_value("o_mod_status after reset", longint'(mod_status), 0);

		step_ref = 0;
		periods = 0;
		half_cycles = 0;
		prev_status = 1'b0;
		have_prev[0] = 1'b0;
		have_prev[1] = 1'b0;
		done = 1'b0;
		mid = int'(row.cfg.freq_cnt) / 2;
		while (!done) begin
			status = mod_status;
			// optical return follows the modulation half
			adc = status ? row.lev_h[ADC_W-1:0] : row.lev_l[ADC_W-1:0];
			if (status != prev_status) begin
				check_value("half length", longint'(half_cycles), longint'(row.cfg.freq_cnt));
				// high to low ends a period and moves the step once
				if (!status) begin
					periods++;
					step_ref = row.cfg.fb_on ? step_ref + (e_ref >>> row.cfg.gain_step)
						: int'(row.cfg.const_step);
				end
				half_cycles = 1;
			end else begin
				half_cycles++;
			end
			prev_status = status;
			if (half_cycles == mid) begin
				// ramp has not moved before the first period ends
				if (periods == 0) begin
					tmp = int'(status ? row.cfg.amp_h : row.cfg.amp_l);
					exp_dac = tmp[DAC_W-1:0];
					check_value("o_dac at mid-half", longint'(dac), longint'(exp_dac));
				end
				check_value("o_err", longint'(err), longint'((periods > 0) ? e_ref : 0));
				check_value("o_step", longint'(step), longint'((periods > 0) ? step_ref : 0));
				// same half one period apart
				if (have_prev[status]) begin
					got_diff = dac - prev_dac[status];
					tmp = step_ref >>> row.cfg.gain_ramp;
					check_value("o_dac change per period", longint'(got_diff),
						longint'(tmp[DAC_W-1:0]));
				end
				prev_dac[status] = dac;
				have_prev[status] = 1'b1;
				if (!status && periods == 3) begin
					check_value("o_err after three periods", longint'(err), longint'(row.exp_err));
					check_value("o_step after three periods", longint'(step),
						longint'(row.exp_step3));
				end
				if (!status && periods == row.periods) begin
					done = 1'b1;
				end
			end
			if (!done) begin
				next_cycle();
			end
		end
	endtask

	// watchdog on the dac clock
	initial begin
		cycle_cnt = 0;
		forever begin
			@(posedge clock_dac_1);
			cycle_cnt++;
			if (cycle_cnt > cycle_limit) begin
				$display("timeout: run did not finish within %0d cycles", cycle_limit);
				$display("*** TEST FAILED ***");
				$fatal(1, "stopped by the cycle limit");
			end
		end
	end

	initial begin
		rst = 1'b1;
		cfg = '0;
		adc = '0;
		rng = 32'd7668;
		// columns are freq amp_h amp_l wait offset const avg gs gr pol fb
		// then lev_h lev_l err step3 periods
		rows[0] = make_row(40, 1000, -1000, 34, 0, 0, 2, 0, 0, 0, 0,
			1000, -1000, 999, 0, 3);
		rows[1] = make_row(48, 8192, 256, 36, 10, 3000, 3, 2, 4, 1, 0,
			2000, -2000, -2009, 3000, 4);
		rows[2] = make_row(64, 5000, -5000, 40, -20, 0, 4, 3, 2, 0, 1,
			4000, 500, 1770, 663, 5);
		// window ends on the last clock of the half
		rows[3] = make_row(36, 0, 0, 34, 0, 0, 1, 1, 0, 1, 1,
			3000, -4000, -3499, -5250, 3);
		rows[4] = make_row(80, 12000, 200, 50, 100, -7000, 4, 0, 1, 0, 0,
			6000, 0, 2899, -7000, 3);
		rows[5] = make_row(50, 300, -300, 45, 0, 0, 0, 4, 3, 0, 1,
			-500, -2000, 750, 138, 4);
		cycle_limit = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			cycle_limit += rows[r].periods * 2 * int'(rows[r].cfg.freq_cnt) + 100;
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(rows[r]);
		end
		if (u_dut.u_mod.u_mod_sva.fail_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("%0d assertion failures in the modulation generator",
				u_dut.u_mod.u_mod_sva.fail_cnt);
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- rtl/fog_adc_fir.sv
module fog_adc_fir (
	input  logic                               CLOCK_DAC_1,
	input  logic                               i_rst,
	input  logic [fog_dsp_pkg::ADC_W-1:0]      i_adc,
	output fog_dsp_pkg::adc_sample_t           o_sample
);

	import fog_dsp_pkg::*;

	// delay line, newest sample in tap 0
	adc_sample_t taps_q [FIR_TAPS];
	// registered tap products
	logic signed [ACC_W-1:0] prod_q [FIR_TAPS];
	logic signed [ACC_W-1:0] sum_d;
	logic signed [ACC_W-1:0] sum_q;
	logic signed [ACC_W-1:0] sum_scaled;

	// edge k captures the sample, k+1 the products
	always_ff @(posedge CLOCK_DAC_1) begin
		taps_q[0] <= i_adc;
		for (int i = 1; i < FIR_TAPS; i++) begin
			taps_q[i] <= taps_q[i-1];
		end
		for (int i = 0; i < FIR_TAPS; i++) begin
			prod_q[i] <= ACC_W'(taps_q[i]) * ACC_W'(fir_coef[i]);
		end
	end

	// adder tree, left to the tool
	always_comb begin
		sum_d = '0;
		for (int i = 0; i < FIR_TAPS; i++) begin
			sum_d = sum_d + prod_q[i];
		end
	end

	// sum lands at edge k+2
	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			sum_q <= '0;
		end else begin
			sum_q <= sum_d;
		end
	end

	// floor division by 2^16, top bits are pure sign
	assign sum_scaled = sum_q >>> FIR_SHIFT;
	assign o_sample = sum_scaled[ADC_W-1:0];

endmodule

//--- rtl/fog_ctrl_pkg.sv
package fog_ctrl_pkg;

	import fog_dsp_pkg::*;

	// modulation half encoding
	localparam logic STATUS_LOW = 1'b0;
	localparam logic STATUS_HIGH = 1'b1;

	// loop settings, held stable outside reset
	typedef struct packed {
		// half-period length in clocks
		loop_word_t  freq_cnt;
		// modulation level, high half
		loop_word_t  amp_h;
		// modulation level, low half
		loop_word_t  amp_l;
		// settling delay before the averaging window opens
		loop_word_t  wait_cnt;
		// subtracted from the demodulated error
		loop_word_t  err_offset;
		// open-loop step
		loop_word_t  const_step;
		// window length is 2^avg_sel samples
		logic [2:0]  avg_sel;
		// error to step gain, right shift
		logic [4:0]  gain_step;
		// step to ramp gain, right shift
		logic [4:0]  gain_ramp;
		// flips the sign of the error
		logic        polarity;
		// 1 closes the loop, 0 uses const_step
		logic        fb_on;
	} loop_cfg_t;

	// timing marks from the modulation generator
	typedef struct packed {
		// 0 low half, 1 high half
		logic status;
		// first cycle of every new half
		logic step_trig;
	} mod_strobe_t;

endpackage

//--- rtl/fog_dsp_pkg.sv
package fog_dsp_pkg;

	// raw adc word from the channel 3 converter
	localparam int ADC_W = 14;
	// fir coefficient width
	localparam int COEF_W = 16;
	localparam int FIR_TAPS = 32;
	// fir sum is brought back to adc scale by this shift
	localparam int FIR_SHIFT = 16;
	// 14 x 16 product plus tap growth, coefficients are all positive
	localparam int ACC_W = 30;
	// loop arithmetic width, matches the register bank word
	localparam int DATA_W = 32;
	localparam int DAC_W = 16;

	// N32FC2 low-pass set, symmetric, dc gain 32762
	localparam logic signed [COEF_W-1:0] fir_coef [FIR_TAPS] = '{
		16'sd82, 16'sd102, 16'sd148, 16'sd223, 16'sd330, 16'sd469, 16'sd638, 16'sd832,
		16'sd1042, 16'sd1261, 16'sd1476, 16'sd1678, 16'sd1855, 16'sd1998, 16'sd2098,
		16'sd2149, 16'sd2149, 16'sd2098, 16'sd1998, 16'sd1855, 16'sd1678, 16'sd1476,
		16'sd1261, 16'sd1042, 16'sd832, 16'sd638, 16'sd469, 16'sd330, 16'sd223,
		16'sd148, 16'sd102, 16'sd82
	};

	// filtered adc sample, two's complement
	typedef logic signed [ADC_W-1:0] adc_sample_t;

	// error, step, ramp and modulation words
	typedef logic signed [DATA_W-1:0] loop_word_t;

	// word sent to the dac, wraps modulo 2^16
	typedef logic [DAC_W-1:0] dac_word_t;

endpackage

//--- rtl/fog_loop_top.sv
module fog_loop_top (
	input  logic                           CLOCK_DAC_1,
	input  logic                           i_rst,
	input  fog_ctrl_pkg::loop_cfg_t        i_cfg,
	input  logic [fog_dsp_pkg::ADC_W-1:0]  i_adc,
	output fog_dsp_pkg::dac_word_t         o_dac,
	output fog_dsp_pkg::loop_word_t        o_err,
	output fog_dsp_pkg::loop_word_t        o_step,
	output logic                           o_mod_status
);

	import fog_dsp_pkg::*;
	import fog_ctrl_pkg::*;

	// filtered adc into the demodulator
	adc_sample_t sample;
	// half status and switch pulse
	mod_strobe_t strobe;
	loop_word_t  mod;
	// step refresh pulse into the ramp
	logic        step_upd;

	fog_adc_fir u_fir (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst       (i_rst),
		.i_adc       (i_adc),
		.o_sample    (sample)
	);

	fog_mod_gen u_mod (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst       (i_rst),
		.i_cfg       (i_cfg),
		.o_strobe    (strobe),
		.o_mod       (mod)
	);

	fog_rate_loop u_loop (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst       (i_rst),
		.i_cfg       (i_cfg),
		.i_sample    (sample),
		.i_strobe    (strobe),
		.o_err       (o_err),
		.o_step      (o_step),
		.o_step_upd  (step_upd)
	);

	fog_phase_ramp u_ramp (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst       (i_rst),
		.i_cfg       (i_cfg),
		.i_mod       (mod),
		.i_step      (o_step),
		.i_step_upd  (step_upd),
		.o_dac       (o_dac)
	);

	// sync out for the modulation half
	assign o_mod_status = strobe.status;

endmodule

//--- rtl/fog_mod_gen.sv
module fog_mod_gen (
	input  logic                       CLOCK_DAC_1,
	input  logic                       i_rst,
	input  fog_ctrl_pkg::loop_cfg_t    i_cfg,
	output fog_ctrl_pkg::mod_strobe_t  o_strobe,
	output fog_dsp_pkg::loop_word_t    o_mod
);

	import fog_dsp_pkg::*;
	import fog_ctrl_pkg::*;

	// clocks spent in the current half
	logic [DATA_W-1:0] half_cnt_q;
	logic [DATA_W-1:0] half_last;
	logic              half_end;
	mod_strobe_t       strobe_q;
	loop_word_t        mod_q;

	// last count of a half
	assign half_last = i_cfg.freq_cnt - 1;
	assign half_end = (half_cnt_q == half_last);

	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			half_cnt_q <= '0;
			strobe_q <= '{status: STATUS_LOW, step_trig: 1'b0};
			// loop starts in the low half
			mod_q <= i_cfg.amp_l;
		end else if (half_end) begin
			half_cnt_q <= '0;
			strobe_q.status <= ~strobe_q.status;
			strobe_q.step_trig <= 1'b1;
			// level follows the half being entered
			mod_q <= (strobe_q.status == STATUS_HIGH) ? i_cfg.amp_l : i_cfg.amp_h;
		end else begin
			half_cnt_q <= half_cnt_q + DATA_W'(1);
			strobe_q.step_trig <= 1'b0;
			mod_q <= (strobe_q.status == STATUS_HIGH) ? i_cfg.amp_h : i_cfg.amp_l;
		end
	end

	assign o_strobe = strobe_q;
	assign o_mod = mod_q;

endmodule

//--- rtl/fog_phase_ramp.sv
module fog_phase_ramp (
	input  logic                     CLOCK_DAC_1,
	input  logic                     i_rst,
	input  fog_ctrl_pkg::loop_cfg_t  i_cfg,
	input  fog_dsp_pkg::loop_word_t  i_mod,
	input  fog_dsp_pkg::loop_word_t  i_step,
	input  logic                     i_step_upd,
	output fog_dsp_pkg::dac_word_t   o_dac
);

	import fog_dsp_pkg::*;

	// phase ramp, wraps at 2^32
	loop_word_t ramp_q;
	loop_word_t ramp_inc;
	loop_word_t dac_sum;
	dac_word_t  dac_q;

	// scaled step, advanced once per period
	assign ramp_inc = i_step >>> i_cfg.gain_ramp;
	assign dac_sum = ramp_q + i_mod;

	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			ramp_q <= '0;
		end else if (i_step_upd) begin
			ramp_q <= ramp_q + ramp_inc;
		end
	end

	// dac word, low bits only, 2pi reset comes from the wrap
	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			dac_q <= '0;
		end else begin
			dac_q <= dac_sum[DAC_W-1:0];
		end
	end

	assign o_dac = dac_q;

endmodule

//--- rtl/fog_rate_loop.sv
module fog_rate_loop (
	input  logic                       CLOCK_DAC_1,
	input  logic                       i_rst,
	input  fog_ctrl_pkg::loop_cfg_t    i_cfg,
	input  fog_dsp_pkg::adc_sample_t   i_sample,
	input  fog_ctrl_pkg::mod_strobe_t  i_strobe,
	output fog_dsp_pkg::loop_word_t    o_err,
	output fog_dsp_pkg::loop_word_t    o_step,
	output logic                       o_step_upd
);

	import fog_dsp_pkg::*;
	import fog_ctrl_pkg::*;

	// position inside the half, 0 on step_trig
	logic [DATA_W-1:0] cnt_q;
	logic [DATA_W-1:0] pos;
	// first position past the window
	logic [DATA_W-1:0] win_end;
	logic              in_win;
	// running window sum and its average
	loop_word_t        acc_q;
	loop_word_t        acc_avg;
	// low half average, kept for the period end
	loop_word_t        avg_l_q;
	loop_word_t        diff;
	logic              period_end;
	loop_word_t        err_q;
	logic              err_upd_q;
	loop_word_t        step_q;
	logic              step_upd_q;

	assign pos = i_strobe.step_trig ? '0 : cnt_q;
	assign win_end = i_cfg.wait_cnt + (DATA_W'(1) << i_cfg.avg_sel);
	// window sits after the fir has settled on the new level
	assign in_win = (pos >= i_cfg.wait_cnt) && (pos < win_end);

	// averaging by shift, window is a power of two
	assign acc_avg = acc_q >>> i_cfg.avg_sel;

	// a new low half closes the period
	assign period_end = i_strobe.step_trig && (i_strobe.status == STATUS_LOW);

	// acc_q still holds the high half here
	assign diff = i_cfg.polarity ? (avg_l_q - acc_avg) : (acc_avg - avg_l_q);

	// reset acts as the start of the first low half
	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= pos + DATA_W'(1);
		end
	end

	// window sum, cleared at every half boundary
	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			acc_q <= '0;
		end else if (i_strobe.step_trig) begin
			acc_q <= '0;
		end else if (in_win) begin
			acc_q <= acc_q + loop_word_t'(i_sample);
		end
	end

	// low half is done once the high half begins
	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_strobe.step_trig && (i_strobe.status == STATUS_HIGH)) begin
			avg_l_q <= acc_avg;
		end
	end

	// error one clock after the period end
	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			err_q <= '0;
			err_upd_q <= 1'b0;
		end else begin
			err_upd_q <= period_end;
			if (period_end) begin
				err_q <= diff - i_cfg.err_offset;
			end
		end
	end

	// feedback step integrator, one clock behind the error
	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			step_q <= '0;
			step_upd_q <= 1'b0;
		end else begin
			step_upd_q <= err_upd_q;
			if (err_upd_q) begin
				// open loop just forces the configured step
				step_q <= i_cfg.fb_on ? step_q + (err_q >>> i_cfg.gain_step) : i_cfg.const_step;
			end
		end
	end

	assign o_err = err_q;
	assign o_step = step_q;
	assign o_step_upd = step_upd_q;

endmodule

//--- vlog.f
rtl/fog_dsp_pkg.sv
rtl/fog_ctrl_pkg.sv
rtl/fog_adc_fir.sv
rtl/fog_mod_gen.sv
rtl/fog_rate_loop.sv
rtl/fog_phase_ramp.sv
rtl/fog_loop_top.sv
bench/fog_loop_sva.sv
bench/tb_fog_loop.sv
